//--- data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  cyc,
    input  wire logic  stb,
    input  wire logic  we,
    input  wire addr_t adr,
    input  wire word_t dat_w,
    input  wire sel_t  sel,
    output word_t      dat_r,
    output logic       ack
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             req;

    // Byte offset is dropped, the rest picks the word
    assign word_idx = adr[IDX_W+1:2];

    // One ack per request, the master drops stb after it
    assign req = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack <= req;
            if (req && we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        mem[word_idx][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

//--- load_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_unit
    import lsu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  load_valid,
    input  wire addr_t load_addr,
    input  wire size_t load_size,
    output logic       load_ready,
    output logic       load_done,
    output word_t      load_data,
    output addr_t      fwd_addr,
    output size_t      fwd_size,
    input  wire logic  fwd_needed,
    input  wire logic  fwd_possible,
    input  wire word_t fwd_value,
    output logic       ld_cyc,
    output logic       ld_stb,
    output logic       ld_we,
    output addr_t      ld_adr,
    output sel_t       ld_sel,
    input  wire logic  ld_ack,
    input  wire word_t ld_dat_r
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_WAIT_DRAIN,
        ST_BUS_READ
    } state_t;

    state_t state;
    addr_t  req_addr;
    size_t  req_size;
    lane_t  req_lane;
    word_t  read_value;

    assign req_lane   = req_addr[1:0];
    assign load_ready = (state == ST_IDLE);

    // Lookup always works on the accepted load
    assign fwd_addr = req_addr;
    assign fwd_size = req_size;

    // Word-aligned read, byte lanes picked afterwards
    assign ld_cyc = (state == ST_BUS_READ);
    assign ld_stb = (state == ST_BUS_READ);
    assign ld_we  = 1'b0;
    assign ld_adr = {req_addr[31:2], 2'b00};
    assign ld_sel = (req_size == SIZE_WORD) ? SEL_WORD : sel_t'(SEL_BYTE0 << req_lane);

    always_comb begin
        if (req_size == SIZE_WORD) begin
            read_value = ld_dat_r;
        end else begin
            read_value = word_t'(8'(ld_dat_r >> {req_lane, 3'b000}));
        end
    end

    assign load_done = (state == ST_CHECK && fwd_needed && fwd_possible) ||
                       (state == ST_BUS_READ && ld_ack);
    assign load_data = (state == ST_CHECK) ? fwd_value : read_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_valid) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (!fwd_needed) begin
                        state <= ST_BUS_READ;
                    end else if (fwd_possible) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_WAIT_DRAIN;
                    end
                end
                // Blocking store has to reach memory first
                ST_WAIT_DRAIN: begin
                    if (!fwd_needed) begin
                        state <= ST_BUS_READ;
                    end
                end
                ST_BUS_READ: begin
                    if (ld_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid && load_ready) begin
            req_addr <= load_addr;
            req_size <= load_size;
        end
    end

endmodule

`default_nettype wire

//--- lsu.f
lsu_pkg.sv
rob_pkg.sv
store_buffer.sv
load_unit.sv
wb_arbiter.sv
data_memory.sv
lsu_top.sv
tb_lsu.sv

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Data and address widths seen by the memory side
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Byte lane inside a word, taken from the low address bits
    typedef logic [1:0] lane_t;

    // Wishbone byte selects, one bit per lane
    typedef logic [3:0] sel_t;

    // Access size of a load or a store
    typedef logic size_t;

    localparam size_t SIZE_BYTE = 1'b0;
    localparam size_t SIZE_WORD = 1'b1;

    // Select patterns for a full word and for lane 0
    localparam sel_t SEL_WORD  = 4'b1111;
    localparam sel_t SEL_BYTE0 = 4'b0001;

endpackage

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
    import rob_pkg::*;
#(
    parameter int SB_ENTRIES = 4,
    parameter int MEM_WORDS  = 64
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    store_valid,
    input  wire addr_t   store_addr,
    input  wire word_t   store_value,
    input  wire size_t   store_size,
    input  wire rob_id_t store_rob_id,
    input  wire logic    tlb_exception,
    input  wire logic    store_permission,
    input  wire rob_id_t permission_rob_id,
    output logic         full,
    input  wire logic    load_valid,
    input  wire addr_t   load_addr,
    input  wire size_t   load_size,
    output logic         load_ready,
    output logic         load_done,
    output word_t        load_data
);

    // Forwarding lookup
    addr_t fwd_addr;
    size_t fwd_size;
    logic  fwd_needed;
    logic  fwd_possible;
    word_t fwd_value;

    // Store drain master
    logic  sb_cyc;
    logic  sb_stb;
    logic  sb_we;
    addr_t sb_adr;
    word_t sb_dat_w;
    sel_t  sb_sel;
    logic  sb_ack;

    // Load master
    logic  ld_cyc;
    logic  ld_stb;
    logic  ld_we;
    addr_t ld_adr;
    sel_t  ld_sel;
    logic  ld_ack;
    word_t ld_dat_r;

    // Shared memory port
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    word_t mem_dat_w;
    sel_t  mem_sel;
    logic  mem_ack;
    word_t mem_dat_r;

    store_buffer #(
        .SB_ENTRIES (SB_ENTRIES)
    ) i_store_buffer (
        .clk               (clk),
        .rst               (rst),
        .store_valid       (store_valid),
        .store_addr        (store_addr),
        .store_value       (store_value),
        .store_size        (store_size),
        .store_rob_id      (store_rob_id),
        .tlb_exception     (tlb_exception),
        .store_permission  (store_permission),
        .permission_rob_id (permission_rob_id),
        .full              (full),
        .fwd_addr          (fwd_addr),
        .fwd_size          (fwd_size),
        .fwd_needed        (fwd_needed),
        .fwd_possible      (fwd_possible),
        .fwd_value         (fwd_value),
        .sb_cyc            (sb_cyc),
        .sb_stb            (sb_stb),
        .sb_we             (sb_we),
        .sb_adr            (sb_adr),
        .sb_dat_w          (sb_dat_w),
        .sb_sel            (sb_sel),
        .sb_ack            (sb_ack)
    );

    load_unit i_load_unit (
        .clk          (clk),
        .rst          (rst),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_size    (load_size),
        .load_ready   (load_ready),
        .load_done    (load_done),
        .load_data    (load_data),
        .fwd_addr     (fwd_addr),
        .fwd_size     (fwd_size),
        .fwd_needed   (fwd_needed),
        .fwd_possible (fwd_possible),
        .fwd_value    (fwd_value),
        .ld_cyc       (ld_cyc),
        .ld_stb       (ld_stb),
        .ld_we        (ld_we),
        .ld_adr       (ld_adr),
        .ld_sel       (ld_sel),
        .ld_ack       (ld_ack),
        .ld_dat_r     (ld_dat_r)
    );

    wb_arbiter i_wb_arbiter (
        .clk       (clk),
        .rst       (rst),
        .sb_cyc    (sb_cyc),
        .sb_stb    (sb_stb),
        .sb_we     (sb_we),
        .sb_adr    (sb_adr),
        .sb_dat_w  (sb_dat_w),
        .sb_sel    (sb_sel),
        .sb_ack    (sb_ack),
        .ld_cyc    (ld_cyc),
        .ld_stb    (ld_stb),
        .ld_we     (ld_we),
        .ld_adr    (ld_adr),
        .ld_sel    (ld_sel),
        .ld_ack    (ld_ack),
        .ld_dat_r  (ld_dat_r),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_sel   (mem_sel),
        .mem_ack   (mem_ack),
        .mem_dat_r (mem_dat_r)
    );

    data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) i_data_memory (
        .clk   (clk),
        .rst   (rst),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_w (mem_dat_w),
        .sel   (mem_sel),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Index of a reorder buffer entry
    typedef logic [3:0] rob_id_t;

    // Reserved id held by free store buffer slots
    localparam rob_id_t ROB_INVALID = '1;

endpackage

`default_nettype wire

//--- store_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module store_buffer
    import lsu_pkg::*;
    import rob_pkg::*;
#(
    parameter int SB_ENTRIES = 4
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    store_valid,
    input  wire addr_t   store_addr,
    input  wire word_t   store_value,
    input  wire size_t   store_size,
    input  wire rob_id_t store_rob_id,
    input  wire logic    tlb_exception,
    input  wire logic    store_permission,
    input  wire rob_id_t permission_rob_id,
    output logic         full,
    input  wire addr_t   fwd_addr,
    input  wire size_t   fwd_size,
    output logic         fwd_needed,
    output logic         fwd_possible,
    output word_t        fwd_value,
    output logic         sb_cyc,
    output logic         sb_stb,
    output logic         sb_we,
    output addr_t        sb_adr,
    output word_t        sb_dat_w,
    output sel_t         sb_sel,
    input  wire logic    sb_ack
);

    localparam int PTR_W = $clog2(SB_ENTRIES);

    addr_t   entry_addr   [SB_ENTRIES];
    word_t   entry_value  [SB_ENTRIES];
    size_t   entry_size   [SB_ENTRIES];
    rob_id_t entry_rob_id [SB_ENTRIES];
    logic    entry_ready  [SB_ENTRIES];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;

    logic  drain_active;
    logic  push;
    logic  pop;
    lane_t head_lane;

    // A store is only kept if it has no TLB exception and there is room
    assign push = store_valid && !full && !tlb_exception;
    assign pop  = drain_active && sb_ack;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Head entry drives the Wishbone write
    assign head_lane = entry_addr[head][1:0];
    assign sb_cyc    = drain_active;
    assign sb_stb    = drain_active;
    assign sb_we     = 1'b1;
    assign sb_adr    = {entry_addr[head][31:2], 2'b00};

    always_comb begin
        if (entry_size[head] == SIZE_WORD) begin
            sb_dat_w = entry_value[head];
            sb_sel   = SEL_WORD;
        end else begin
            sb_dat_w = word_t'(entry_value[head][7:0]) << {head_lane, 3'b000};
            sb_sel   = sel_t'(SEL_BYTE0 << head_lane);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            full         <= 1'b0;
            drain_active <= 1'b0;
            for (int i = 0; i < SB_ENTRIES; i++) begin
                entry_ready[i]  <= 1'b0;
                entry_rob_id[i] <= ROB_INVALID;
            end
        end else begin
            // ROB permission, matched by id across all slots
            for (int i = 0; i < SB_ENTRIES; i++) begin
                if (store_permission && entry_rob_id[i] == permission_rob_id) begin
                    entry_ready[i] <= 1'b1;
                end
            end

            if (pop) begin
                entry_ready[head]  <= 1'b0;
                entry_rob_id[head] <= ROB_INVALID;
                head               <= head + 1'b1;
            end

            if (push) begin
                entry_ready[tail]  <= 1'b0;
                entry_rob_id[tail] <= store_rob_id;
                tail               <= tail + 1'b1;
            end

            // Start a write once the head is permitted, stop at ack
            if (pop) begin
                drain_active <= 1'b0;
            end else if (!drain_active && count != '0 && entry_ready[head]) begin
                drain_active <= 1'b1;
            end

            count <= count_next;
            full  <= (count_next == (PTR_W+1)'(SB_ENTRIES));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_addr[tail]  <= store_addr;
            entry_value[tail] <= store_value;
            entry_size[tail]  <= store_size;
        end
    end

    // Scan head to tail so the youngest match is the one left standing
    always_comb begin : fwd_lookup
        logic [PTR_W-1:0] idx;
        lane_t            diff;
        idx          = '0;
        diff         = '0;
        fwd_needed   = 1'b0;
        fwd_possible = 1'b0;
        fwd_value    = '0;
        for (int j = 0; j < SB_ENTRIES; j++) begin
            idx  = head + PTR_W'(j);
            diff = fwd_addr[1:0] - entry_addr[idx][1:0];
            if (j < int'(count) && entry_addr[idx][31:2] == fwd_addr[31:2]) begin
                if (fwd_size == SIZE_WORD) begin
                    // Any byte store inside the word blocks forwarding
                    fwd_needed   = 1'b1;
                    fwd_possible = (entry_size[idx] == SIZE_WORD);
                    fwd_value    = entry_value[idx];
                end else if (entry_size[idx] == SIZE_WORD) begin
                    fwd_needed   = 1'b1;
                    fwd_possible = 1'b1;
                    fwd_value    = word_t'(8'(entry_value[idx] >> {diff, 3'b000}));
                end else if (diff == '0) begin
                    fwd_needed   = 1'b1;
                    fwd_possible = 1'b1;
                    fwd_value    = word_t'(entry_value[idx][7:0]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu
    import lsu_pkg::*;
    import rob_pkg::*;
;

    localparam int SB_ENTRIES   = 4;
    localparam int MEM_WORDS    = 64;
    localparam int CLK_PERIOD   = 4;
    localparam int ROW_CYCLES   = 200;
    localparam int RAND_GROUPS  = 24;
    localparam int unsigned RAND_SEED = 24905;

    typedef enum logic [1:0] {
        OP_STORE,
        OP_PERMIT,
        OP_LOAD,
        OP_IDLE
    } op_t;

    // One stimulus row; data holds the cycle count for idle rows
    typedef struct packed {
        op_t     op;
        addr_t   addr;
        size_t   size;
        word_t   data;
        rob_id_t rob;
        logic    tlb;
        logic    exp_full;
    } row_t;

    // Store that the model still holds outside its memory image
    typedef struct packed {
        addr_t   addr;
        size_t   size;
        word_t   data;
        rob_id_t rob;
        logic    permitted;
    } pend_t;

    logic    clk;
    logic    rst;
    logic    store_valid;
    addr_t   store_addr;
    word_t   store_value;
    size_t   store_size;
    rob_id_t store_rob_id;
    logic    tlb_exception;
    logic    store_permission;
    rob_id_t permission_rob_id;
    logic    full;
    logic    load_valid;
    addr_t   load_addr;
    size_t   load_size;
    logic    load_ready;
    logic    load_done;
    word_t   load_data;

    row_t    rows [$];
    pend_t   pending [$];
    word_t   img [MEM_WORDS];
    rob_id_t next_rob;
    int      fail_count;
    longint  watchdog_ns;
    logic    table_ready;

    lsu_top #(
        .SB_ENTRIES (SB_ENTRIES),
        .MEM_WORDS  (MEM_WORDS)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .store_valid       (store_valid),
        .store_addr        (store_addr),
        .store_value       (store_value),
        .store_size        (store_size),
        .store_rob_id      (store_rob_id),
        .tlb_exception     (tlb_exception),
        .store_permission  (store_permission),
        .permission_rob_id (permission_rob_id),
        .full              (full),
        .load_valid        (load_valid),
        .load_addr         (load_addr),
        .load_size         (load_size),
        .load_ready        (load_ready),
        .load_done         (load_done),
        .load_data         (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_count++;
            report_failure($sformatf("MISMATCH at %0t ns: %s expected 0x%08h, got 0x%08h",
                                     $time, name, expected, actual));
        end
    endtask

    // Table builders
    task automatic add_store(input addr_t a, input size_t s, input word_t d, input logic tlb,
                             input logic exp_full, output rob_id_t id);
        id = next_rob;
        // Id 15 is reserved for empty slots, so ids wrap at 14
        next_rob = (next_rob == ROB_INVALID - 1) ? '0 : next_rob + 1'b1;
        rows.push_back('{OP_STORE, a, s, d, id, tlb, exp_full});
    endtask

    task automatic add_permit(input rob_id_t id);
        rows.push_back('{OP_PERMIT, '0, SIZE_WORD, '0, id, 1'b0, 1'b0});
    endtask

    task automatic add_load(input addr_t a, input size_t s);
        rows.push_back('{OP_LOAD, a, s, '0, '0, 1'b0, 1'b0});
    endtask

    task automatic add_idle(input int cycles, input logic exp_full);
        rows.push_back('{OP_IDLE, '0, SIZE_WORD, word_t'(cycles), '0, 1'b0, exp_full});
    endtask

    // Reference model
    function automatic word_t merge_store(word_t w, addr_t a, size_t s, word_t d);
        word_t r;
        r = w;
        if (s == SIZE_WORD) begin
            r = d;
        end else begin
            r[{a[1:0], 3'b000} +: 8] = d[7:0];
        end
        return r;
    endfunction

    function automatic word_t model_load(addr_t a, size_t s);
        word_t w;
        w = img[int'(a[31:2])];
        // Every store still pending is older than the load
        foreach (pending[i]) begin
            if (pending[i].addr[31:2] == a[31:2]) begin
                w = merge_store(w, pending[i].addr, pending[i].size, pending[i].data);
            end
        end
        if (s == SIZE_BYTE) begin
            w = {24'h0, w[{a[1:0], 3'b000} +: 8]};
        end
        return w;
    endfunction

    task automatic model_permit(input rob_id_t id);
        foreach (pending[i]) begin
            if (pending[i].rob == id) begin
                pending[i].permitted = 1'b1;
            end
        end
        // Retire in FIFO order, as the buffer drains
        while (pending.size() > 0 && pending[0].permitted) begin
            img[int'(pending[0].addr[31:2])] = merge_store(img[int'(pending[0].addr[31:2])],
                                                           pending[0].addr, pending[0].size,
                                                           pending[0].data);
            void'(pending.pop_front());
        end
    endtask

    // Each row starts and ends just after a falling edge
    task automatic apply_row(input row_t row);
        word_t expected;
        case (row.op)
            OP_STORE: begin
                if (row.exp_full) begin
                    check_value("full", 32'd1, {31'b0, full});
                end else begin
                    while (full) @(negedge clk);
                end
                store_valid   = 1'b1;
                store_addr    = row.addr;
                store_value   = row.data;
                store_size    = row.size;
                store_rob_id  = row.rob;
                tlb_exception = row.tlb;
                @(negedge clk);
                store_valid   = 1'b0;
                tlb_exception = 1'b0;
                if (!row.exp_full && !row.tlb) begin
                    pending.push_back('{row.addr, row.size, row.data, row.rob, 1'b0});
                end
            end
            OP_PERMIT: begin
                store_permission  = 1'b1;
                permission_rob_id = row.rob;
                @(negedge clk);
                store_permission  = 1'b0;
                model_permit(row.rob);
            end
            OP_LOAD: begin
                while (!load_ready) @(negedge clk);
                expected   = model_load(row.addr, row.size);
                load_valid = 1'b1;
                load_addr  = row.addr;
                load_size  = row.size;
                @(negedge clk);
                load_valid = 1'b0;
                while (!load_done) @(negedge clk);
                check_value("load_data", expected, load_data);
                // Done lasts a single cycle
                @(negedge clk);
                check_value("load_done", 32'd0, {31'b0, load_done});
            end
            default: begin
                repeat (int'(row.data)) @(negedge clk);
                check_value("full", {31'b0, row.exp_full}, {31'b0, full});
            end
        endcase
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        report_failure("Timeout: the stimulus table did not finish in the allowed time");
    end

    initial begin
        rob_id_t id_a;
        rob_id_t id_b;
        rob_id_t ids [SB_ENTRIES];
        addr_t   a_addr;
        addr_t   b_addr;
        addr_t   l_addr;
        size_t   a_size;
        size_t   l_size;
        word_t   a_data;

        rst               = 1'b1;
        store_valid       = 1'b0;
        store_addr        = '0;
        store_value       = '0;
        store_size        = SIZE_WORD;
        store_rob_id      = '0;
        tlb_exception     = 1'b0;
        store_permission  = 1'b0;
        permission_rob_id = '0;
        load_valid        = 1'b0;
        load_addr         = '0;
        load_size         = SIZE_WORD;
        next_rob          = '0;
        fail_count        = 0;
        watchdog_ns       = 0;
        table_ready       = 1'b0;
        foreach (img[i]) img[i] = '0;
        void'($urandom(RAND_SEED));

        // Store, drain, read back, and an untouched word
        add_store(32'h10, SIZE_WORD, 32'hDEAD_BEEF, 1'b0, 1'b0, id_a);
        add_permit(id_a);
        add_idle(8, 1'b0);
        add_load(32'h10, SIZE_WORD);
        add_load(32'h20, SIZE_WORD);

        // Byte loads forwarded from a word store still waiting for the ROB
        add_store(32'h30, SIZE_WORD, 32'h1122_3344, 1'b0, 1'b0, id_a);
        for (int k = 0; k < 4; k++) begin
            add_load(32'h30 + k, SIZE_BYTE);
        end
        add_permit(id_a);
        add_idle(8, 1'b0);

        // Youngest store wins, then a byte store blocks the word load
        add_store(32'h40, SIZE_WORD, 32'hAAAA_0001, 1'b0, 1'b0, id_a);
        add_store(32'h40, SIZE_WORD, 32'hBBBB_0002, 1'b0, 1'b0, id_b);
        add_load(32'h40, SIZE_WORD);
        add_permit(id_a);
        add_permit(id_b);
        add_store(32'h42, SIZE_BYTE, 32'h0000_005C, 1'b0, 1'b0, id_a);
        add_load(32'h42, SIZE_BYTE);
        add_permit(id_a);
        add_load(32'h40, SIZE_WORD);
        add_idle(20, 1'b0);

        // Fill the buffer, drop one store, permit in reverse order
        for (int k = 0; k < SB_ENTRIES; k++) begin
            if (k % 2 == 0) begin
                add_store(32'h50, SIZE_WORD, 32'h0101_0101 * (k + 1), 1'b0, 1'b0, ids[k]);
            end else begin
                add_store(32'h51, SIZE_BYTE, 32'h70 + k, 1'b0, 1'b0, ids[k]);
            end
        end
        add_store(32'h58, SIZE_WORD, 32'hFFFF_FFFF, 1'b0, 1'b1, id_a);
        for (int k = SB_ENTRIES - 1; k >= 0; k--) begin
            add_permit(ids[k]);
        end
        add_load(32'h50, SIZE_WORD);
        add_load(32'h58, SIZE_WORD);
        add_idle(20, 1'b0);
        add_load(32'h51, SIZE_BYTE);

        // TLB exception drops the store
        add_store(32'h10, SIZE_WORD, 32'h1234_5678, 1'b1, 1'b0, id_a);
        add_idle(4, 1'b0);
        add_load(32'h10, SIZE_WORD);

        // Random groups; B is always a word store so no load waits on the ROB
        for (int g = 0; g < RAND_GROUPS; g++) begin
            a_size = size_t'($urandom() % 2);
            a_addr = addr_t'($urandom() % (MEM_WORDS * 4));
            a_data = $urandom();
            if (a_size == SIZE_WORD) begin
                a_addr[1:0] = 2'b00;
            end else begin
                a_data = a_data & 32'hFF;
            end
            b_addr = ($urandom() % 2) ? {a_addr[31:2], 2'b00}
                                      : addr_t'(($urandom() % MEM_WORDS) * 4);
            l_size = size_t'($urandom() % 2);
            l_addr = ($urandom() % 2) ? {a_addr[31:2], 2'(($urandom()))}
                                      : addr_t'($urandom() % (MEM_WORDS * 4));
            if (l_size == SIZE_WORD) begin
                l_addr[1:0] = 2'b00;
            end
            add_store(a_addr, a_size, a_data, 1'b0, 1'b0, id_a);
            add_store(b_addr, SIZE_WORD, $urandom(), 1'b0, 1'b0, id_b);
            add_permit(id_a);
            add_load(l_addr, l_size);
            add_permit(id_b);
        end
        add_idle(20, 1'b0);
        add_load(a_addr, a_size);

        watchdog_ns = longint'(rows.size()) * ROW_CYCLES * CLK_PERIOD;
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle outputs straight out of reset
        check_value("full", 32'd0, {31'b0, full});
        check_value("load_ready", 32'd1, {31'b0, load_ready});
        check_value("load_done", 32'd0, {31'b0, load_done});

        foreach (rows[r]) begin
            apply_row(rows[r]);
        end

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_failure("Checks failed during the run");
        end
    end

endmodule

`default_nettype wire

//--- wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
    import lsu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  sb_cyc,
    input  wire logic  sb_stb,
    input  wire logic  sb_we,
    input  wire addr_t sb_adr,
    input  wire word_t sb_dat_w,
    input  wire sel_t  sb_sel,
    output logic       sb_ack,
    input  wire logic  ld_cyc,
    input  wire logic  ld_stb,
    input  wire logic  ld_we,
    input  wire addr_t ld_adr,
    input  wire sel_t  ld_sel,
    output logic       ld_ack,
    output word_t      ld_dat_r,
    output logic       mem_cyc,
    output logic       mem_stb,
    output logic       mem_we,
    output addr_t      mem_adr,
    output word_t      mem_dat_w,
    output sel_t       mem_sel,
    input  wire logic  mem_ack,
    input  wire word_t mem_dat_r
);

    typedef enum logic [1:0] {
        OWNER_IDLE,
        OWNER_LD,
        OWNER_SB
    } owner_t;

    owner_t owner;
    logic   locked_ld;
    logic   locked_sb;
    logic   grant_ld;
    logic   grant_sb;

    // The owner keeps the bus while its cyc stays high
    assign locked_ld = (owner == OWNER_LD) && ld_cyc;
    assign locked_sb = (owner == OWNER_SB) && sb_cyc;

    // Loads win when nobody holds the bus
    assign grant_ld = locked_ld || (!locked_sb && ld_cyc);
    assign grant_sb = locked_sb || (!locked_ld && !ld_cyc && sb_cyc);

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWNER_IDLE;
        end else if (grant_ld) begin
            owner <= OWNER_LD;
        end else if (grant_sb) begin
            owner <= OWNER_SB;
        end else begin
            owner <= OWNER_IDLE;
        end
    end

    always_comb begin
        mem_cyc   = 1'b0;
        mem_stb   = 1'b0;
        mem_we    = 1'b0;
        mem_adr   = '0;
        mem_dat_w = '0;
        mem_sel   = '0;
        if (grant_ld) begin
            mem_cyc = ld_cyc;
            mem_stb = ld_stb;
            mem_we  = ld_we;
            mem_adr = ld_adr;
            mem_sel = ld_sel;
        end else if (grant_sb) begin
            mem_cyc   = sb_cyc;
            mem_stb   = sb_stb;
            mem_we    = sb_we;
            mem_adr   = sb_adr;
            mem_dat_w = sb_dat_w;
            mem_sel   = sb_sel;
        end
    end

    assign ld_ack   = mem_ack && grant_ld;
    assign sb_ack   = mem_ack && grant_sb;
    assign ld_dat_r = mem_dat_r;

endmodule

`default_nettype wire
